// ==== rtl/issue_defs.svh ====
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// reservation station
`define RS_SZ 8
`define RS_IDX_BITS 3

// functional units per type
`define NUM_FU_ALU 2
`define NUM_FU_MULT 2
`define NUM_FU_BRANCH 1
`define NUM_FU_TOTAL 5

// result bus lanes
`define CDB_N 2

// physical register file and datapath
`define PRF_SZ 32
`define TAG_BITS 5
`define DATA_BITS 32
`define FUNC_BITS 4

`endif

// ==== rtl/issue_pkg.sv ====
`default_nettype none

`include "issue_defs.svh"

package issue_pkg;

    // ldst is decoded upstream but never issued here
    typedef enum logic [1:0] {
        fu_alu    = 2'd0,
        fu_mult   = 2'd1,
        fu_branch = 2'd2,
        fu_ldst   = 2'd3
    } fu_type_e;

    // one reservation station slot as seen by issue
    typedef struct packed {
        logic [31:0]            pc;
        fu_type_e               fu_type;
        logic [`FUNC_BITS-1:0]  func;
        logic [`TAG_BITS-1:0]   dest_tag;
        logic [`TAG_BITS-1:0]   src1_tag;
        logic [`TAG_BITS-1:0]   src2_tag;
        logic                   src1_ready;
        logic                   src2_ready;
        // branch only, conditional vs jump
        logic                   conditional;
    } rs_entry_t;

    // one result bus lane
    typedef struct packed {
        logic                   valid;
        logic [`TAG_BITS-1:0]   tag;
        logic [`DATA_BITS-1:0]  result;
    } cdb_entry_t;

    typedef struct packed {
        logic                   valid;
        logic [31:0]            pc;
        logic [`TAG_BITS-1:0]   dest_tag;
        logic [`FUNC_BITS-1:0]  func;
        logic [`DATA_BITS-1:0]  src1_value;
        logic [`DATA_BITS-1:0]  src2_value;
    } alu_packet_t;

    // multiplier needs no pc
    typedef struct packed {
        logic                   valid;
        logic [`TAG_BITS-1:0]   dest_tag;
        logic [`FUNC_BITS-1:0]  func;
        logic [`DATA_BITS-1:0]  src1_value;
        logic [`DATA_BITS-1:0]  src2_value;
    } mult_packet_t;

    typedef struct packed {
        logic                   valid;
        logic [31:0]            pc;
        logic [`TAG_BITS-1:0]   dest_tag;
        logic [`FUNC_BITS-1:0]  func;
        logic [`DATA_BITS-1:0]  src1_value;
        logic [`DATA_BITS-1:0]  src2_value;
        logic                   conditional;
    } branch_packet_t;

endpackage

`default_nettype wire

// ==== rtl/psel_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module psel_gen #(
    parameter int WIDTH = 8,
    parameter int REQS  = 2
) (
    input  wire logic [WIDTH-1:0]            req,
    // union of every row below
    output logic      [WIDTH-1:0]            gnt,
    output logic      [REQS-1:0][WIDTH-1:0]  gnt_bus
);

    // requests not yet handed to a row
    logic [WIDTH-1:0] remaining;

    always_comb begin
        remaining = req;
        gnt_bus   = '0;
        for (int r = 0; r < REQS; r++) begin
            // isolate lowest set bit
            gnt_bus[r] = remaining & (~remaining + 1'b1);
            remaining  = remaining & ~gnt_bus[r];
        end
        // whatever got cleared was granted
        gnt = req & ~remaining;
    end

endmodule

`default_nettype wire

// ==== rtl/issue_select.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "issue_defs.svh"

module issue_select (
    input  issue_pkg::rs_entry_t [`RS_SZ-1:0]  rs_entries,
    input  wire logic [`RS_SZ-1:0]             rs_valid,
    input  wire logic [`NUM_FU_MULT-1:0]       mult_free,
    input  wire logic [`NUM_FU_MULT-1:0]       mult_cdb_req,
    output logic [`NUM_FU_ALU-1:0][`RS_SZ-1:0]       alu_gnt_bus,
    output logic [`NUM_FU_MULT-1:0][`RS_SZ-1:0]      mult_gnt_bus,
    output logic [`NUM_FU_BRANCH-1:0][`RS_SZ-1:0]    branch_gnt_bus,
    output logic [`NUM_FU_MULT-1:0][`NUM_FU_MULT-1:0] mult_fu_gnt_bus,
    output logic [`NUM_FU_MULT-1:0]            mult_cdb_gnt,
    output logic [`RS_SZ-1:0]                  rs_lane_gnt
);

    logic [`RS_SZ-1:0] entry_ready;
    logic [`RS_SZ-1:0] alu_ready;
    logic [`RS_SZ-1:0] mult_ready;
    logic [`RS_SZ-1:0] branch_ready;

    // valid with both operands ready, then split by unit type
    always_comb begin
        for (int e = 0; e < `RS_SZ; e++) begin
            entry_ready[e]  = rs_valid[e] && rs_entries[e].src1_ready
                              && rs_entries[e].src2_ready;
            alu_ready[e]    = entry_ready[e] && (rs_entries[e].fu_type == issue_pkg::fu_alu);
            mult_ready[e]   = entry_ready[e] && (rs_entries[e].fu_type == issue_pkg::fu_mult);
            branch_ready[e] = entry_ready[e]
                              && (rs_entries[e].fu_type == issue_pkg::fu_branch);
        end
    end

    // per type, lowest index entries first
    psel_gen #(.WIDTH(`RS_SZ), .REQS(`NUM_FU_ALU)) u_alu_psel (
        .req     (alu_ready),
        .gnt     (),
        .gnt_bus (alu_gnt_bus)
    );

    psel_gen #(.WIDTH(`RS_SZ), .REQS(`NUM_FU_MULT)) u_mult_psel (
        .req     (mult_ready),
        .gnt     (),
        .gnt_bus (mult_gnt_bus)
    );

    psel_gen #(.WIDTH(`RS_SZ), .REQS(`NUM_FU_BRANCH)) u_branch_psel (
        .req     (branch_ready),
        .gnt     (),
        .gnt_bus (branch_gnt_bus)
    );

    // slot k pairs with the k-th free multiplier
    psel_gen #(.WIDTH(`NUM_FU_MULT), .REQS(`NUM_FU_MULT)) u_mult_fu_psel (
        .req     (mult_free),
        .gnt     (),
        .gnt_bus (mult_fu_gnt_bus)
    );

    // lane arbitration, finishing multipliers sit at the low end and win
    psel_gen #(.WIDTH(`RS_SZ + `NUM_FU_MULT), .REQS(`CDB_N)) u_lane_psel (
        .req     ({alu_ready | branch_ready, mult_cdb_req}),
        .gnt     ({rs_lane_gnt, mult_cdb_gnt}),
        .gnt_bus ()
    );

endmodule

`default_nettype wire

// ==== rtl/operand_resolver.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "issue_defs.svh"

module operand_resolver (
    input  wire logic [`TAG_BITS-1:0]          tag,
    // complete_list bit for this tag
    input  wire logic                          complete,
    input  wire logic [`DATA_BITS-1:0]         rf_data,
    input  issue_pkg::cdb_entry_t [`CDB_N-1:0] cdb,
    output logic [`DATA_BITS-1:0]              value
);

    always_comb begin
        // no source found reads as zero
        value = '0;
        if (complete) begin
            // already written back, take the register file
            value = rf_data;
        end else begin
            // forward from the bus, later lanes override earlier ones
            for (int j = 0; j < `CDB_N; j++) begin
                if (cdb[j].valid && (cdb[j].tag == tag)) begin
                    value = cdb[j].result;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/issue_dispatch.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "issue_defs.svh"

module issue_dispatch (
    input  issue_pkg::rs_entry_t [`RS_SZ-1:0]  rs_entries,
    input  wire logic [`PRF_SZ-1:0]            complete_list,
    input  issue_pkg::cdb_entry_t [`CDB_N-1:0] cdb,
    input  wire logic [`NUM_FU_ALU-1:0][`RS_SZ-1:0]       alu_gnt_bus,
    input  wire logic [`NUM_FU_MULT-1:0][`RS_SZ-1:0]      mult_gnt_bus,
    input  wire logic [`NUM_FU_BRANCH-1:0][`RS_SZ-1:0]    branch_gnt_bus,
    input  wire logic [`NUM_FU_MULT-1:0][`NUM_FU_MULT-1:0] mult_fu_gnt_bus,
    input  wire logic [`RS_SZ-1:0]             rs_lane_gnt,
    // register file data, [slot][source]
    input  wire logic [`NUM_FU_ALU-1:0][1:0][`DATA_BITS-1:0]    alu_read_data,
    input  wire logic [`NUM_FU_MULT-1:0][1:0][`DATA_BITS-1:0]   mult_read_data,
    input  wire logic [`NUM_FU_BRANCH-1:0][1:0][`DATA_BITS-1:0] branch_read_data,
    output logic [`NUM_FU_ALU-1:0][1:0][`TAG_BITS-1:0]    alu_read_tag,
    output logic [`NUM_FU_MULT-1:0][1:0][`TAG_BITS-1:0]   mult_read_tag,
    output logic [`NUM_FU_BRANCH-1:0][1:0][`TAG_BITS-1:0] branch_read_tag,
    output issue_pkg::alu_packet_t [`NUM_FU_ALU-1:0]       alu_packets,
    output issue_pkg::mult_packet_t [`NUM_FU_MULT-1:0]     mult_packets,
    output issue_pkg::branch_packet_t [`NUM_FU_BRANCH-1:0] branch_packets,
    output logic [`RS_SZ-1:0]                  rs_issuing,
    output logic [`NUM_FU_TOTAL-1:0]           unit_cdb_req
);

    localparam int MULT_BASE   = `NUM_FU_ALU;
    localparam int BRANCH_BASE = `NUM_FU_ALU + `NUM_FU_MULT;

    // all slots flattened, ALUs first, then multipliers, then branch
    logic [`NUM_FU_TOTAL-1:0][`RS_SZ-1:0]             slot_gnt;
    logic [`NUM_FU_TOTAL-1:0][1:0][`DATA_BITS-1:0]    slot_data;
    logic [`NUM_FU_TOTAL-1:0][1:0][`TAG_BITS-1:0]     slot_tag;
    logic [`NUM_FU_TOTAL-1:0][1:0][`DATA_BITS-1:0]    slot_val;
    logic [`NUM_FU_TOTAL-1:0]                         slot_issue;
    issue_pkg::rs_entry_t [`NUM_FU_TOTAL-1:0]         slot_ent;

    // one-hot to binary, OR encoder
    function automatic logic [`RS_IDX_BITS-1:0] onehot_idx(input logic [`RS_SZ-1:0] oh);
        logic [`RS_IDX_BITS-1:0] idx;
        idx = '0;
        for (int b = 0; b < `RS_SZ; b++) begin
            if (oh[b]) idx = idx | `RS_IDX_BITS'(b);
        end
        return idx;
    endfunction

    assign slot_gnt  = {branch_gnt_bus, mult_gnt_bus, alu_gnt_bus};
    assign slot_data = {branch_read_data, mult_read_data, alu_read_data};
    assign {branch_read_tag, mult_read_tag, alu_read_tag} = slot_tag;

    for (genvar s = 0; s < `NUM_FU_TOTAL; s++) begin : g_slot
        assign slot_ent[s] = rs_entries[onehot_idx(slot_gnt[s])];

        // single-cycle slots need a lane, multiplier slots a free unit
        if (s >= MULT_BASE && s < BRANCH_BASE) begin : g_mult_issue
            assign slot_issue[s] = (|slot_gnt[s]) && (|mult_fu_gnt_bus[s-MULT_BASE]);
        end else begin : g_lane_issue
            assign slot_issue[s] = |(slot_gnt[s] & rs_lane_gnt);
        end

        // idle slots read tag zero
        assign slot_tag[s][0] = slot_issue[s] ? slot_ent[s].src1_tag : '0;
        assign slot_tag[s][1] = slot_issue[s] ? slot_ent[s].src2_tag : '0;

        for (genvar k = 0; k < 2; k++) begin : g_src
            operand_resolver u_operand_resolver (
                .tag      (slot_tag[s][k]),
                .complete (complete_list[slot_tag[s][k]]),
                .rf_data  (slot_data[s][k]),
                .cdb      (cdb),
                .value    (slot_val[s][k])
            );
        end
    end

    // multipliers claim their lane through mult_cdb_gnt instead
    assign unit_cdb_req = {slot_issue[`NUM_FU_TOTAL-1:BRANCH_BASE], {`NUM_FU_MULT{1'b0}},
                           slot_issue[MULT_BASE-1:0]};

    always_comb begin
        rs_issuing = '0;
        for (int s = 0; s < `NUM_FU_TOTAL; s++) begin
            rs_issuing = rs_issuing | (slot_gnt[s] & {`RS_SZ{slot_issue[s]}});
        end
    end

    always_comb begin
        alu_packets    = '0;
        mult_packets   = '0;
        branch_packets = '0;
        for (int a = 0; a < `NUM_FU_ALU; a++) begin
            if (slot_issue[a]) begin
                alu_packets[a] = {1'b1, slot_ent[a].pc, slot_ent[a].dest_tag,
                                  slot_ent[a].func, slot_val[a][0], slot_val[a][1]};
            end
        end
        // packet lands at the position of the free unit paired with slot m
        for (int m = 0; m < `NUM_FU_MULT; m++) begin
            for (int u = 0; u < `NUM_FU_MULT; u++) begin
                if (slot_issue[MULT_BASE+m] && mult_fu_gnt_bus[m][u]) begin
                    mult_packets[u] = {1'b1, slot_ent[MULT_BASE+m].dest_tag,
                                       slot_ent[MULT_BASE+m].func,
                                       slot_val[MULT_BASE+m][0], slot_val[MULT_BASE+m][1]};
                end
            end
        end
        for (int b = 0; b < `NUM_FU_BRANCH; b++) begin
            if (slot_issue[BRANCH_BASE+b]) begin
                branch_packets[b] = {1'b1, slot_ent[BRANCH_BASE+b].pc,
                                     slot_ent[BRANCH_BASE+b].dest_tag,
                                     slot_ent[BRANCH_BASE+b].func,
                                     slot_val[BRANCH_BASE+b][0], slot_val[BRANCH_BASE+b][1],
                                     slot_ent[BRANCH_BASE+b].conditional};
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/complete_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "issue_defs.svh"

module complete_arbiter (
    input  wire logic                        clock,
    input  wire logic                        reset,
    // ALU and branch lanes, multiplier bits left zero
    input  wire logic [`NUM_FU_TOTAL-1:0]    unit_cdb_req,
    input  wire logic [`NUM_FU_MULT-1:0]     mult_cdb_gnt,
    output logic [`CDB_N-1:0][`NUM_FU_TOTAL-1:0] complete_gnt_bus
);

    logic [`NUM_FU_TOTAL-1:0]                  unit_req;
    logic [`CDB_N-1:0][`NUM_FU_TOTAL-1:0]      next_gnt_bus;

    // drop multiplier grants into their unit positions
    assign unit_req = unit_cdb_req
                      | {{`NUM_FU_BRANCH{1'b0}}, mult_cdb_gnt, {`NUM_FU_ALU{1'b0}}};

    // lane j goes to the j-th requesting unit
    psel_gen #(.WIDTH(`NUM_FU_TOTAL), .REQS(`CDB_N)) u_lane_psel (
        .req     (unit_req),
        .gnt     (),
        .gnt_bus (next_gnt_bus)
    );

    // result bus drivers see their lane one cycle later
    always_ff @(posedge clock) begin
        if (reset) begin
            complete_gnt_bus <= '0;
        end else begin
            complete_gnt_bus <= next_gnt_bus;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/issue_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "issue_defs.svh"

module issue_stage (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  issue_pkg::rs_entry_t [`RS_SZ-1:0]  rs_entries,
    input  wire logic [`RS_SZ-1:0]             rs_valid,
    input  wire logic [`PRF_SZ-1:0]            complete_list,
    input  issue_pkg::cdb_entry_t [`CDB_N-1:0] cdb,
    input  wire logic [`NUM_FU_ALU-1:0][1:0][`DATA_BITS-1:0]    alu_read_data,
    input  wire logic [`NUM_FU_MULT-1:0][1:0][`DATA_BITS-1:0]   mult_read_data,
    input  wire logic [`NUM_FU_BRANCH-1:0][1:0][`DATA_BITS-1:0] branch_read_data,
    input  wire logic [`NUM_FU_MULT-1:0]       mult_free,
    input  wire logic [`NUM_FU_MULT-1:0]       mult_cdb_req,
    output logic [`NUM_FU_ALU-1:0][1:0][`TAG_BITS-1:0]    alu_read_tag,
    output logic [`NUM_FU_MULT-1:0][1:0][`TAG_BITS-1:0]   mult_read_tag,
    output logic [`NUM_FU_BRANCH-1:0][1:0][`TAG_BITS-1:0] branch_read_tag,
    output issue_pkg::alu_packet_t [`NUM_FU_ALU-1:0]       alu_packets,
    output issue_pkg::mult_packet_t [`NUM_FU_MULT-1:0]     mult_packets,
    output issue_pkg::branch_packet_t [`NUM_FU_BRANCH-1:0] branch_packets,
    output logic [`RS_SZ-1:0]                  rs_issuing,
    output logic [`NUM_FU_MULT-1:0]            mult_cdb_gnt,
    output logic [`CDB_N-1:0][`NUM_FU_TOTAL-1:0] complete_gnt_bus
);

    logic [`NUM_FU_ALU-1:0][`RS_SZ-1:0]        alu_gnt_bus;
    logic [`NUM_FU_MULT-1:0][`RS_SZ-1:0]       mult_gnt_bus;
    logic [`NUM_FU_BRANCH-1:0][`RS_SZ-1:0]     branch_gnt_bus;
    logic [`NUM_FU_MULT-1:0][`NUM_FU_MULT-1:0] mult_fu_gnt_bus;
    logic [`RS_SZ-1:0]                         rs_lane_gnt;
    logic [`NUM_FU_TOTAL-1:0]                  unit_cdb_req;

    issue_select u_issue_select (
        .rs_entries, .rs_valid, .mult_free, .mult_cdb_req,
        .alu_gnt_bus, .mult_gnt_bus, .branch_gnt_bus,
        .mult_fu_gnt_bus, .mult_cdb_gnt, .rs_lane_gnt
    );

    issue_dispatch u_issue_dispatch (
        .rs_entries, .complete_list, .cdb,
        .alu_gnt_bus, .mult_gnt_bus, .branch_gnt_bus, .mult_fu_gnt_bus, .rs_lane_gnt,
        .alu_read_data, .mult_read_data, .branch_read_data,
        .alu_read_tag, .mult_read_tag, .branch_read_tag,
        .alu_packets, .mult_packets, .branch_packets,
        .rs_issuing, .unit_cdb_req
    );

    complete_arbiter u_complete_arbiter (
        .clock, .reset, .unit_cdb_req, .mult_cdb_gnt, .complete_gnt_bus
    );

endmodule

`default_nettype wire

// ==== testbench/issue_stage_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "issue_defs.svh"

module issue_stage_tb;

    localparam int CLOCK_PERIOD = 40;
    localparam int RESET_CYCLES = 8;
    localparam int TEST_CYCLES  = 300;
    localparam int NUM_TESTS    = 5;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * TEST_CYCLES + 100;

    logic clock;
    logic reset;
    issue_pkg::rs_entry_t [`RS_SZ-1:0]  rs_entries;
    logic [`RS_SZ-1:0]                  rs_valid;
    logic [`PRF_SZ-1:0]                 complete_list;
    issue_pkg::cdb_entry_t [`CDB_N-1:0] cdb;
    logic [`NUM_FU_MULT-1:0]            mult_free;
    logic [`NUM_FU_MULT-1:0]            mult_cdb_req;
    logic [`NUM_FU_ALU-1:0][1:0][`DATA_BITS-1:0]    alu_read_data;
    logic [`NUM_FU_MULT-1:0][1:0][`DATA_BITS-1:0]   mult_read_data;
    logic [`NUM_FU_BRANCH-1:0][1:0][`DATA_BITS-1:0] branch_read_data;
    logic [`NUM_FU_ALU-1:0][1:0][`TAG_BITS-1:0]     alu_read_tag;
    logic [`NUM_FU_MULT-1:0][1:0][`TAG_BITS-1:0]    mult_read_tag;
    logic [`NUM_FU_BRANCH-1:0][1:0][`TAG_BITS-1:0]  branch_read_tag;
    issue_pkg::alu_packet_t [`NUM_FU_ALU-1:0]       alu_packets;
    issue_pkg::mult_packet_t [`NUM_FU_MULT-1:0]     mult_packets;
    issue_pkg::branch_packet_t [`NUM_FU_BRANCH-1:0] branch_packets;
    logic [`RS_SZ-1:0]                  rs_issuing;
    logic [`NUM_FU_MULT-1:0]            mult_cdb_gnt;
    logic [`CDB_N-1:0][`NUM_FU_TOTAL-1:0] complete_gnt_bus;

    // expected values from the reference model
    issue_pkg::alu_packet_t [`NUM_FU_ALU-1:0]       exp_alu_packets;
    issue_pkg::mult_packet_t [`NUM_FU_MULT-1:0]     exp_mult_packets;
    issue_pkg::branch_packet_t [`NUM_FU_BRANCH-1:0] exp_branch_packets;
    logic [`NUM_FU_ALU-1:0][1:0][`TAG_BITS-1:0]     exp_alu_tag;
    logic [`NUM_FU_MULT-1:0][1:0][`TAG_BITS-1:0]    exp_mult_tag;
    logic [`NUM_FU_BRANCH-1:0][1:0][`TAG_BITS-1:0]  exp_branch_tag;
    logic [`RS_SZ-1:0]                  exp_issuing;
    logic [`RS_SZ-1:0]                  exp_ready;
    logic [`NUM_FU_MULT-1:0]            exp_mult_cdb_gnt;
    // grant the register should hold after the next rising edge
    logic [`CDB_N-1:0][`NUM_FU_TOTAL-1:0] exp_complete_gnt;

    logic [31:0] rng_state;
    int check_count;
    int error_count;
    int errors_before;

    issue_stage u_issue_stage (
        .clock, .reset, .rs_entries, .rs_valid, .complete_list, .cdb,
        .alu_read_data, .mult_read_data, .branch_read_data, .mult_free, .mult_cdb_req,
        .alu_read_tag, .mult_read_tag, .branch_read_tag,
        .alu_packets, .mult_packets, .branch_packets,
        .rs_issuing, .mult_cdb_gnt, .complete_gnt_bus
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // true with roughly pct percent probability
    function automatic logic chance(input int pct);
        logic [31:0] r;
        r = rand32();
        return (r % 100) < pct;
    endfunction

    // register file contents as a pure function of the tag
    function automatic logic [`DATA_BITS-1:0] rf_value(input logic [`TAG_BITS-1:0] tag);
        return `DATA_BITS'(tag) * 32'h0101_0101 + 32'h0000_1000;
    endfunction

    // register file answers whatever tags the DUT reads
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            for (int s = 0; s < `NUM_FU_ALU; s++) begin
                alu_read_data[s][k] = rf_value(alu_read_tag[s][k]);
            end
            for (int s = 0; s < `NUM_FU_MULT; s++) begin
                mult_read_data[s][k] = rf_value(mult_read_tag[s][k]);
            end
            for (int s = 0; s < `NUM_FU_BRANCH; s++) begin
                branch_read_data[s][k] = rf_value(branch_read_tag[s][k]);
            end
        end
    end

    // written-back value, else newest bus lane with that tag, else zero
    function automatic logic [`DATA_BITS-1:0] operand_value(input logic [`TAG_BITS-1:0] tag);
        if (complete_list[tag]) return rf_value(tag);
        for (int j = `CDB_N - 1; j >= 0; j--) begin
            if (cdb[j].valid && cdb[j].tag == tag) return cdb[j].result;
        end
        return '0;
    endfunction

    // position of the k-th free multiplier, -1 when there is none
    function automatic int free_unit(input int k);
        int seen;
        seen = 0;
        for (int u = 0; u < `NUM_FU_MULT; u++) begin
            if (mult_free[u]) begin
                if (seen == k) return u;
                seen++;
            end
        end
        return -1;
    endfunction

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED time %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // random snapshot, bias depends on the test
    task automatic drive_inputs(input int test_id);
        logic [31:0] r;
        int pick;
        for (int e = 0; e < `RS_SZ; e++) begin
            r = rand32();
            rs_entries[e].pc = rand32();
            rs_entries[e].fu_type = issue_pkg::fu_type_e'(r[1:0]);
            // back-pressure test is multiplier heavy
            if (test_id == 2 && chance(70)) rs_entries[e].fu_type = issue_pkg::fu_mult;
            rs_entries[e].func = r[5:2];
            rs_entries[e].dest_tag = r[10:6];
            rs_entries[e].src1_tag = r[15:11];
            rs_entries[e].src2_tag = r[20:16];
            rs_entries[e].conditional = r[21];
            rs_entries[e].src1_ready = chance(test_id == 4 ? 90 : 65);
            rs_entries[e].src2_ready = chance(test_id == 4 ? 90 : 65);
            rs_valid[e] = chance(test_id == 4 ? 95 : 70);
        end
        complete_list = rand32();
        // mostly incomplete tags so operands come off the bus
        if (test_id == 1) complete_list = complete_list & rand32() & rand32();
        for (int j = 0; j < `CDB_N; j++) begin
            r = rand32();
            cdb[j].valid = chance(test_id == 1 ? 90 : 50);
            cdb[j].result = rand32();
            cdb[j].tag = r[`TAG_BITS-1:0];
            pick = r[8 +: `RS_IDX_BITS];
            if (test_id == 1 || chance(30)) begin
                cdb[j].tag = r[7] ? rs_entries[pick].src1_tag : rs_entries[pick].src2_tag;
            end
        end
        r = rand32();
        mult_free = r[`NUM_FU_MULT-1:0];
        if (test_id == 2 && chance(40)) mult_free = '0;
        mult_cdb_req = r[8 +: `NUM_FU_MULT];
        if (test_id == 3) begin
            for (int m = 0; m < `NUM_FU_MULT; m++) mult_cdb_req[m] = chance(75);
        end
    endtask

    // reference model of selection, lanes, operands and completion grant
    task automatic compute_expected();
        issue_pkg::rs_entry_t ent;
        logic [`NUM_FU_TOTAL-1:0] unit_req;
        int lanes_used;
        int alu_cnt;
        int mult_cnt;
        int branch_cnt;
        int unit;
        logic has_lane;
        exp_alu_packets = '0;
        exp_mult_packets = '0;
        exp_branch_packets = '0;
        exp_alu_tag = '0;
        exp_mult_tag = '0;
        exp_branch_tag = '0;
        exp_issuing = '0;
        exp_mult_cdb_gnt = '0;
        exp_complete_gnt = '0;
        unit_req = '0;
        lanes_used = 0;
        alu_cnt = 0;
        mult_cnt = 0;
        branch_cnt = 0;
        // finishing multipliers claim lanes before anyone else
        for (int m = 0; m < `NUM_FU_MULT; m++) begin
            if (mult_cdb_req[m] && lanes_used < `CDB_N) begin
                exp_mult_cdb_gnt[m] = 1'b1;
                lanes_used++;
            end
        end
        for (int e = 0; e < `RS_SZ; e++) begin
            ent = rs_entries[e];
            exp_ready[e] = rs_valid[e] && ent.src1_ready && ent.src2_ready
                           && ent.fu_type != issue_pkg::fu_ldst;
            has_lane = 1'b0;
            // single-cycle entries take lanes in index order, slot or not
            if (exp_ready[e] && ent.fu_type != issue_pkg::fu_mult && lanes_used < `CDB_N) begin
                has_lane = 1'b1;
                lanes_used++;
            end
            if (exp_ready[e] && ent.fu_type == issue_pkg::fu_alu) begin
                if (alu_cnt < `NUM_FU_ALU && has_lane) begin
                    exp_alu_packets[alu_cnt].valid = 1'b1;
                    exp_alu_packets[alu_cnt].pc = ent.pc;
                    exp_alu_packets[alu_cnt].dest_tag = ent.dest_tag;
                    exp_alu_packets[alu_cnt].func = ent.func;
                    exp_alu_packets[alu_cnt].src1_value = operand_value(ent.src1_tag);
                    exp_alu_packets[alu_cnt].src2_value = operand_value(ent.src2_tag);
                    exp_alu_tag[alu_cnt] = {ent.src2_tag, ent.src1_tag};
                    exp_issuing[e] = 1'b1;
                    unit_req[alu_cnt] = 1'b1;
                end
                alu_cnt++;
            end
            if (exp_ready[e] && ent.fu_type == issue_pkg::fu_branch) begin
                if (branch_cnt < `NUM_FU_BRANCH && has_lane) begin
                    exp_branch_packets[branch_cnt].valid = 1'b1;
                    exp_branch_packets[branch_cnt].pc = ent.pc;
                    exp_branch_packets[branch_cnt].dest_tag = ent.dest_tag;
                    exp_branch_packets[branch_cnt].func = ent.func;
                    exp_branch_packets[branch_cnt].src1_value = operand_value(ent.src1_tag);
                    exp_branch_packets[branch_cnt].src2_value = operand_value(ent.src2_tag);
                    exp_branch_packets[branch_cnt].conditional = ent.conditional;
                    exp_branch_tag[branch_cnt] = {ent.src2_tag, ent.src1_tag};
                    exp_issuing[e] = 1'b1;
                    unit_req[`NUM_FU_ALU + `NUM_FU_MULT + branch_cnt] = 1'b1;
                end
                branch_cnt++;
            end
            // slot k goes to the k-th free unit, packet lands at that unit
            if (exp_ready[e] && ent.fu_type == issue_pkg::fu_mult) begin
                unit = free_unit(mult_cnt);
                if (mult_cnt < `NUM_FU_MULT && unit >= 0) begin
                    exp_mult_packets[unit].valid = 1'b1;
                    exp_mult_packets[unit].dest_tag = ent.dest_tag;
                    exp_mult_packets[unit].func = ent.func;
                    exp_mult_packets[unit].src1_value = operand_value(ent.src1_tag);
                    exp_mult_packets[unit].src2_value = operand_value(ent.src2_tag);
                    exp_mult_tag[mult_cnt] = {ent.src2_tag, ent.src1_tag};
                    exp_issuing[e] = 1'b1;
                end
                mult_cnt++;
            end
        end
        // unit order is ALUs, multipliers, branch; lowest unit gets lane 0
        unit_req[`NUM_FU_ALU +: `NUM_FU_MULT] = exp_mult_cdb_gnt;
        lanes_used = 0;
        for (int u = 0; u < `NUM_FU_TOTAL; u++) begin
            if (unit_req[u] && lanes_used < `CDB_N) begin
                exp_complete_gnt[lanes_used][u] = 1'b1;
                lanes_used++;
            end
        end
    endtask

    task automatic check_outputs();
        int lane_use;
        lane_use = 0;
        for (int a = 0; a < `NUM_FU_ALU; a++) begin
            check_value(alu_packets[a], exp_alu_packets[a], $sformatf("alu packet %0d", a));
            lane_use += alu_packets[a].valid;
        end
        for (int m = 0; m < `NUM_FU_MULT; m++) begin
            check_value(mult_packets[m], exp_mult_packets[m], $sformatf("mult packet %0d", m));
            lane_use += mult_cdb_gnt[m];
        end
        for (int b = 0; b < `NUM_FU_BRANCH; b++) begin
            check_value(branch_packets[b], exp_branch_packets[b],
                        $sformatf("branch packet %0d", b));
            lane_use += branch_packets[b].valid;
        end
        check_value(rs_issuing, exp_issuing, "rs_issuing");
        check_value(rs_issuing & ~exp_ready, '0, "unready, invalid or ldst entry issued");
        check_value(mult_cdb_gnt, exp_mult_cdb_gnt, "mult_cdb_gnt");
        check_value(lane_use <= `CDB_N, 1'b1, "more results than result bus lanes");
        check_value(alu_read_tag, exp_alu_tag, "alu read tags");
        check_value(mult_read_tag, exp_mult_tag, "mult read tags");
        check_value(branch_read_tag, exp_branch_tag, "branch read tags");
    endtask

    function automatic string test_name(input int test_id);
        case (test_id)
            0: return "random mix";
            1: return "operand forwarding";
            2: return "multiplier back-pressure";
            3: return "lane pressure";
            default: return "dense ready";
        endcase
    endfunction

    // ends a hung run
    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("timeout: simulation still running after %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        rs_entries = '0;
        rs_valid = '0;
        complete_list = '0;
        cdb = '0;
        mult_free = '0;
        // finishing multipliers keep asking for lanes while reset is held
        mult_cdb_req = '1;
        rng_state = 32'h57a6;
        check_count = 0;
        error_count = 0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_value(complete_gnt_bus, '0, "complete_gnt_bus right after reset");
        for (int t = 0; t < NUM_TESTS; t++) begin
            errors_before = error_count;
            for (int c = 0; c < TEST_CYCLES; c++) begin
                drive_inputs(t);
                compute_expected();
                @(negedge clock);
                check_outputs();
                // registered one edge after the requests that made it
                check_value(complete_gnt_bus, exp_complete_gnt, "complete_gnt_bus");
            end
            $display("test %0d (%s): %0d cycles, %0d errors", t, test_name(t), TEST_CYCLES,
                     error_count - errors_before);
        end
        $display("finished: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+rtl
rtl/issue_pkg.sv
rtl/psel_gen.sv
rtl/issue_select.sv
rtl/operand_resolver.sv
rtl/issue_dispatch.sv
rtl/complete_arbiter.sv
rtl/issue_stage.sv
testbench/issue_stage_tb.sv
